/* compile.f */
design/line_pkg.sv
design/op_if.sv
design/result_if.sv
design/req_port.sv
design/tag_store.sv
design/lru_list.sv
design/resp_stage.sv
design/line_tracker_top.sv
verif/line_tracker_properties.sv
verif/line_tracker_tb.sv

/* Bender.yml */
package:
  name: line_tracker

sources:
  - files:
      - design/line_pkg.sv
      - design/op_if.sv
      - design/result_if.sv
      - design/req_port.sv
      - design/tag_store.sv
      - design/lru_list.sv
      - design/resp_stage.sv
      - design/line_tracker_top.sv
  - target: test
    files:
      - verif/line_tracker_properties.sv
      - verif/line_tracker_tb.sv

/* verif/line_tracker_tb.sv */
`timescale 1ns/1ps

module line_tracker_tb;
    import line_pkg::*;

    localparam int lines      = DEF_LINES;
    localparam int idx_w      = DEF_INDEX_W;
    localparam int tag_w      = $clog2(lines);
    localparam int clk_period = 100;
    localparam int num_rand   = 40;
    localparam int num_ops    = 29 + num_rand;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               req;
    op_e                req_op;
    logic [idx_w-1:0]   req_index;
    logic [tag_w-1:0]   req_tag;
    logic               ack;
    resp_e              resp_code;
    logic [tag_w-1:0]   resp_tag;
    line_state_e        resp_status;
    logic [idx_w-1:0]   resp_index;
    logic               writeback;

    integer seed = 7;

    // model order array keeps the most recent line in front
    line_state_e      m_st  [lines];
    logic [idx_w-1:0] m_idx [lines];
    int               m_order [$];
    int               m_unused;

    resp_e       e_code;
    int          e_tag;
    line_state_e e_status;
    int          e_index;
    int          e_wb;

    resp_e            last_code;
    logic [tag_w-1:0] last_tag;
    line_state_e      last_status;
    logic [idx_w-1:0] last_index;
    logic             last_wb;

    line_tracker_top #(.lines(lines), .index_w(idx_w)) i_line_tracker_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_op      (req_op),
        .req_index   (req_index),
        .req_tag     (req_tag),
        .ack         (ack),
        .resp_code   (resp_code),
        .resp_tag    (resp_tag),
        .resp_status (resp_status),
        .resp_index  (resp_index),
        .writeback   (writeback)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_code(input string name, input resp_e got, input resp_e exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %s expected %s",
                                     $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_status(input string name, input line_state_e got,
                                input line_state_e exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %s expected %s",
                                     $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_outputs(input resp_e c, input int t, input line_state_e s,
                                   input int i, input int w);
        check_code("resp_code", resp_code, c);
        check_value("resp_tag", resp_tag, t);
        check_status("resp_status", resp_status, s);
        check_value("resp_index", resp_index, i);
        check_value("writeback", writeback, w);
    endtask

    function automatic void move_to_front(input int t);
        for (int i = 0; i < m_order.size(); i++) begin
            if (m_order[i] == t) begin
                m_order.delete(i);
                break;
            end
        end
        m_order.push_front(t);
    endfunction

    task automatic predict_op(input op_e op, input int index, input int tag);
        int hit_t;
        int v;
        hit_t = -1;
        for (int i = 0; i < lines; i++) begin
            if (m_st[i] != st_invalid && m_idx[i] == index) hit_t = i;
        end
        e_code   = resp_miss;
        e_tag    = 0;
        e_status = st_invalid;
        e_index  = 0;
        e_wb     = 0;
        if (hit_t >= 0 && (op == op_lookup || op == op_alloc)) begin
            e_code   = resp_hit;
            e_tag    = hit_t;
            e_status = m_st[hit_t];
            e_index  = m_idx[hit_t];
            move_to_front(hit_t);
        end else if (op == op_write && hit_t >= 0) begin
            if (m_st[hit_t] == st_filling) begin
                e_code = resp_busy;
            end else begin
                m_st[hit_t] = st_dirty;
                e_code      = resp_done;
                e_tag       = hit_t;
                e_status    = st_dirty;
                e_index     = m_idx[hit_t];
                move_to_front(hit_t);
            end
        end else if (op == op_alloc) begin
            // never-used lines go first from the highest tag down
            v = (m_unused > 0) ? m_unused - 1 : m_order[m_order.size() - 1];
            if (m_st[v] == st_filling) begin
                e_code = resp_busy;
            end else begin
                e_code   = resp_done;
                e_tag    = v;
                e_status = m_st[v];
                e_index  = m_idx[v];
                e_wb     = (m_st[v] == st_dirty);
                if (m_unused > 0) m_unused--;
                m_st[v]  = st_filling;
                m_idx[v] = index;
                move_to_front(v);
            end
        end else if (op == op_fill_done && m_st[tag] == st_filling) begin
            m_st[tag] = st_clean;
            e_code    = resp_done;
            e_tag     = tag;
            e_status  = st_clean;
            e_index   = m_idx[tag];
        end
    endtask

    // one four-phase exchange with 0 to 3 extra cycles of req
    task automatic do_op(input op_e op, input int index, input int tag);
        int extra;
        int waited;
        predict_op(op, index, tag);
        extra = $unsigned($random(seed)) % 4;
        @(posedge clk);
        req       <= 1'b1;
        req_op    <= op;
        req_index <= idx_w'(index);
        req_tag   <= tag_w'(tag);
        waited = 0;
        @(negedge clk);
        while (!ack && waited < 4) begin
            waited++;
            @(negedge clk);
        end
        if (!ack) report_failure("ack never rose for a pending request");
        compare_outputs(e_code, e_tag, e_status, e_index, e_wb);
        last_code   = resp_code;
        last_tag    = resp_tag;
        last_status = resp_status;
        last_index  = resp_index;
        last_wb     = writeback;
        repeat (extra) begin
            @(negedge clk);
            check_value("ack", ack, 1);
            compare_outputs(e_code, e_tag, e_status, e_index, e_wb);
        end
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (ack && waited < 1) begin
            waited++;
            @(negedge clk);
        end
        if (ack) report_failure("ack stayed high after req was dropped");
    endtask

    task automatic test_reset_lookup();
        check_value("ack", ack, 0);
        do_op(op_lookup, 5, 0);
        check_code("resp_code", last_code, resp_miss);
    endtask

    task automatic test_alloc_fill();
        for (int i = 0; i < 4; i++) begin
            do_op(op_alloc, i + 1, 0);
            check_value("resp_tag", last_tag, 3 - i);
            check_status("resp_status", last_status, st_invalid);
            check_value("writeback", last_wb, 0);
        end
        do_op(op_lookup, 1, 0);
        check_status("resp_status", last_status, st_filling);
        do_op(op_write, 1, 0);
        check_code("resp_code", last_code, resp_busy);
    endtask

    task automatic test_fill_write();
        do_op(op_fill_done, 0, 3);
        check_code("resp_code", last_code, resp_done);
        do_op(op_lookup, 1, 0);
        check_status("resp_status", last_status, st_clean);
        do_op(op_write, 1, 0);
        check_code("resp_code", last_code, resp_done);
        do_op(op_lookup, 1, 0);
        check_status("resp_status", last_status, st_dirty);
        do_op(op_fill_done, 0, 3);
        check_code("resp_code", last_code, resp_miss);
        for (int t = 2; t >= 0; t--) do_op(op_fill_done, 0, t);
    endtask

    task automatic test_evict();
        // leaves recency as idx 2 then 4 then 1 then 3
        do_op(op_lookup, 3, 0);
        do_op(op_lookup, 1, 0);
        do_op(op_lookup, 4, 0);
        do_op(op_lookup, 2, 0);
        do_op(op_alloc, 9, 0);
        check_value("resp_index", last_index, 3);
        check_value("writeback", last_wb, 0);
        do_op(op_alloc, 10, 0);
        check_status("resp_status", last_status, st_dirty);
        check_value("writeback", last_wb, 1);
    endtask

    task automatic test_busy();
        // leaves the filling line of idx 9 at the tail
        do_op(op_lookup, 4, 0);
        do_op(op_lookup, 2, 0);
        do_op(op_lookup, 10, 0);
        do_op(op_alloc, 11, 0);
        check_code("resp_code", last_code, resp_busy);
        do_op(op_lookup, 9, 0);
        check_status("resp_status", last_status, st_filling);
        do_op(op_lookup, 11, 0);
        check_code("resp_code", last_code, resp_miss);
        do_op(op_alloc, 2, 0);
        check_code("resp_code", last_code, resp_hit);
    endtask

    task automatic test_random();
        op_e op;
        int  index;
        int  tag;
        for (int n = 0; n < num_rand; n++) begin
            op    = op_e'($unsigned($random(seed)) % 4);
            index = $unsigned($random(seed)) % 8;
            tag   = $unsigned($random(seed)) % lines;
            do_op(op, index, tag);
        end
    endtask

    // hang guard allows 10 cycles per exchange plus reset
    initial begin
        #((num_ops * 10 + 8) * clk_period);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n     = 1'b0;
        req       = 1'b0;
        req_op    = op_lookup;
        req_index = '0;
        req_tag   = '0;
        for (int i = 0; i < lines; i++) begin
            m_st[i]  = st_invalid;
            m_idx[i] = '0;
        end
        m_unused = lines;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        test_reset_lookup();
        test_alloc_fill();
        test_fill_write();
        test_evict();
        test_busy();
        test_random();
        $display("Verification passed");
        $finish;
    end

endmodule

/* verif/line_tracker_properties.sv */
`timescale 1ns/1ps

module line_tracker_properties (
    input logic            clk,
    input logic            rst_n,
    input logic            req,
    input logic            ack,
    input line_pkg::resp_e resp_code
);

    // ack only answers a pending request
    assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
        else $error("ack rose without a request");

    assert property (@(posedge clk) disable iff (!rst_n) (ack && req) |=> ack)
        else $error("ack dropped while req was still high");

    // four-phase release
    assert property (@(posedge clk) disable iff (!rst_n) $fell(req) |-> ##[0:1] !ack)
        else $error("ack did not fall after req fell");

    assert property (@(posedge clk) disable iff (!rst_n) ack |-> !$isunknown(resp_code))
        else $error("resp_code unknown while ack is high");

endmodule

bind line_tracker_top line_tracker_properties i_line_tracker_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .resp_code (resp_code)
);

/* design/line_tracker_top.sv */
`timescale 1ns/1ps

module line_tracker_top #(
    parameter int lines   = line_pkg::DEF_LINES,
    parameter int index_w = line_pkg::DEF_INDEX_W
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req,
    input  line_pkg::op_e                req_op,
    input  logic [index_w-1:0]           req_index,
    input  logic [$clog2(lines)-1:0]     req_tag,
    output logic                         ack,
    output line_pkg::resp_e              resp_code,
    output logic [$clog2(lines)-1:0]     resp_tag,
    output line_pkg::line_state_e        resp_status,
    output logic [index_w-1:0]           resp_index,
    output logic                         writeback
);
    localparam int tag_w = $clog2(lines);

    logic             touch;
    logic [tag_w-1:0] touch_tag;
    logic             touch_alloc;
    logic [tag_w-1:0] victim_tag;

    op_if #(.lines(lines), .index_w(index_w)) op_bus ();
    result_if #(.lines(lines), .index_w(index_w)) res_bus ();

    req_port #(.lines(lines), .index_w(index_w)) i_req_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ack       (ack),
        .req_op    (req_op),
        .req_index (req_index),
        .req_tag   (req_tag),
        .op        (op_bus.source)
    );

    tag_store #(.lines(lines), .index_w(index_w)) i_tag_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .op          (op_bus.sink),
        .res         (res_bus.source),
        .victim_tag  (victim_tag),
        .touch       (touch),
        .touch_tag   (touch_tag),
        .touch_alloc (touch_alloc)
    );

    lru_list #(.lines(lines), .index_w(index_w)) i_lru_list (
        .clk         (clk),
        .rst_n       (rst_n),
        .touch       (touch),
        .touch_tag   (touch_tag),
        .touch_alloc (touch_alloc),
        .victim_tag  (victim_tag)
    );

    resp_stage #(.lines(lines), .index_w(index_w)) i_resp_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .res         (res_bus.sink),
        .resp_code   (resp_code),
        .resp_tag    (resp_tag),
        .resp_status (resp_status),
        .resp_index  (resp_index),
        .writeback   (writeback)
    );

endmodule

/* design/resp_stage.sv */
`timescale 1ns/1ps

module resp_stage #(
    parameter int lines   = line_pkg::DEF_LINES,
    parameter int index_w = line_pkg::DEF_INDEX_W
) (
    input  logic                     clk,
    input  logic                     rst_n,
    result_if.sink                   res,
    output line_pkg::resp_e          resp_code,
    output logic [$clog2(lines)-1:0] resp_tag,
    output line_pkg::line_state_e    resp_status,
    output logic [index_w-1:0]       resp_index,
    output logic                     writeback
);
    import line_pkg::*;

    logic no_data;

    // miss and busy carry no line information
    assign no_data = (res.code == resp_miss) || (res.code == resp_busy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_code   <= resp_miss;
            resp_tag    <= '0;
            resp_status <= st_invalid;
            resp_index  <= '0;
            writeback   <= 1'b0;
        end else if (res.valid) begin
            resp_code   <= res.code;
            resp_tag    <= no_data ? '0 : res.tag;
            resp_status <= no_data ? st_invalid : res.status;
            resp_index  <= no_data ? '0 : res.index;
            writeback   <= res.victim_dirty && (res.code == resp_done);
        end
    end

endmodule

/* design/lru_list.sv */
`timescale 1ns/1ps

module lru_list #(
    parameter int lines   = line_pkg::DEF_LINES,
    parameter int index_w = line_pkg::DEF_INDEX_W
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     touch,
    input  logic [$clog2(lines)-1:0] touch_tag,
    input  logic                     touch_alloc,
    output logic [$clog2(lines)-1:0] victim_tag
);
    localparam int tag_w = $clog2(lines);

    logic [tag_w-1:0] prv [lines];
    logic [tag_w-1:0] nxt [lines];
    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [tag_w:0]   len;
    // lines never claimed, handed out from the top down
    logic [tag_w:0]   unused;
    logic             t_is_head;
    logic             t_is_tail;

    assign t_is_head  = (touch_tag == head);
    assign t_is_tail  = (touch_tag == tail);
    assign victim_tag = (unused != '0) ? tag_w'(unused - 1'b1) : tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < lines; i++) begin
                prv[i] <= '0;
                nxt[i] <= '0;
            end
            head   <= '0;
            tail   <= '0;
            len    <= '0;
            unused <= (tag_w + 1)'(lines);
        end else if (touch && touch_alloc) begin
            // new line goes straight to the head
            nxt[touch_tag] <= head;
            if (len != '0) begin
                prv[head] <= touch_tag;
            end else begin
                tail <= touch_tag;
            end
            head   <= touch_tag;
            len    <= len + 1'b1;
            unused <= unused - 1'b1;
        end else if (touch && !t_is_head) begin
            // unlink, then reinsert at head
            nxt[prv[touch_tag]] <= nxt[touch_tag];
            if (t_is_tail) begin
                tail <= prv[touch_tag];
            end else begin
                prv[nxt[touch_tag]] <= prv[touch_tag];
            end
            nxt[touch_tag] <= head;
            prv[head]      <= touch_tag;
            head           <= touch_tag;
        end
    end

endmodule

/* design/tag_store.sv */
`timescale 1ns/1ps

module tag_store #(
    parameter int lines   = line_pkg::DEF_LINES,
    parameter int index_w = line_pkg::DEF_INDEX_W
) (
    input  logic                     clk,
    input  logic                     rst_n,
    op_if.sink                       op,
    result_if.source                 res,
    input  logic [$clog2(lines)-1:0] victim_tag,
    output logic                     touch,
    output logic [$clog2(lines)-1:0] touch_tag,
    output logic                     touch_alloc
);
    import line_pkg::*;

    localparam int tag_w = $clog2(lines);

    line_state_e        line_st  [lines];
    logic [index_w-1:0] line_idx [lines];
    logic               hit;
    logic [tag_w-1:0]   hit_tag;
    logic               touch_req;
    logic               upd;
    logic [tag_w-1:0]   upd_tag;
    line_state_e        upd_state;
    logic [index_w-1:0] upd_index;

    // hit search over every valid line
    always_comb begin
        hit     = 1'b0;
        hit_tag = '0;
        for (int i = 0; i < lines; i++) begin
            if (line_st[i] != st_invalid && line_idx[i] == op.index) begin
                hit     = 1'b1;
                hit_tag = tag_w'(i);
            end
        end
    end

    always_comb begin
        res.code         = resp_miss;
        res.tag          = '0;
        res.status       = st_invalid;
        res.index        = '0;
        res.victim_dirty = 1'b0;
        touch_req        = 1'b0;
        touch_tag        = '0;
        touch_alloc      = 1'b0;
        upd              = 1'b0;
        upd_tag          = '0;
        upd_state        = st_invalid;
        upd_index        = '0;
        if (hit && (op.op == op_lookup || op.op == op_alloc)) begin
            res.code   = resp_hit;
            res.tag    = hit_tag;
            res.status = line_st[hit_tag];
            res.index  = line_idx[hit_tag];
            touch_req  = 1'b1;
            touch_tag  = hit_tag;
        end else begin
            case (op.op)
                op_write: begin
                    if (hit && line_st[hit_tag] == st_filling) begin
                        res.code = resp_busy;
                    end else if (hit) begin
                        res.code   = resp_done;
                        res.tag    = hit_tag;
                        res.status = st_dirty;
                        res.index  = line_idx[hit_tag];
                        touch_req  = 1'b1;
                        touch_tag  = hit_tag;
                        upd        = 1'b1;
                        upd_tag    = hit_tag;
                        upd_state  = st_dirty;
                        upd_index  = line_idx[hit_tag];
                    end
                end
                op_alloc: begin
                    if (line_st[victim_tag] == st_filling) begin
                        res.code = resp_busy;
                    end else begin
                        // report what the victim held before the claim
                        res.code         = resp_done;
                        res.tag          = victim_tag;
                        res.status       = line_st[victim_tag];
                        res.index        = line_idx[victim_tag];
                        res.victim_dirty = (line_st[victim_tag] == st_dirty);
                        touch_req        = 1'b1;
                        touch_tag        = victim_tag;
                        touch_alloc      = (line_st[victim_tag] == st_invalid);
                        upd              = 1'b1;
                        upd_tag          = victim_tag;
                        upd_state        = st_filling;
                        upd_index        = op.index;
                    end
                end
                op_fill_done: begin
                    if (line_st[op.tag] == st_filling) begin
                        res.code   = resp_done;
                        res.tag    = op.tag;
                        res.status = st_clean;
                        res.index  = line_idx[op.tag];
                        upd        = 1'b1;
                        upd_tag    = op.tag;
                        upd_state  = st_clean;
                        upd_index  = line_idx[op.tag];
                    end
                end
                default: begin
                    res.code = resp_miss;
                end
            endcase
        end
    end

    assign res.valid = op.valid;
    assign touch     = op.valid && touch_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < lines; i++) begin
                line_st[i]  <= st_invalid;
                line_idx[i] <= '0;
            end
        end else if (op.valid && upd) begin
            line_st[upd_tag]  <= upd_state;
            line_idx[upd_tag] <= upd_index;
        end
    end

endmodule

/* design/req_port.sv */
`timescale 1ns/1ps

module req_port #(
    parameter int lines   = line_pkg::DEF_LINES,
    parameter int index_w = line_pkg::DEF_INDEX_W
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req,
    output logic                     ack,
    input  line_pkg::op_e            req_op,
    input  logic [index_w-1:0]       req_index,
    input  logic [$clog2(lines)-1:0] req_tag,
    op_if.source                     op
);
    import line_pkg::*;

    localparam int tag_w = $clog2(lines);

    typedef enum logic [1:0] {idle, issue, hold} state_e;

    state_e             state;
    op_e                op_q;
    logic [index_w-1:0] index_q;
    logic [tag_w-1:0]   tag_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle:    if (req) state <= issue;
                issue:   state <= hold;
                hold:    if (!req) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // operands are stable while req is high, one capture is enough
    always_ff @(posedge clk) begin
        if (state == idle && req) begin
            op_q    <= req_op;
            index_q <= req_index;
            tag_q   <= req_tag;
        end
    end

    assign op.valid = (state == issue);
    assign op.op    = op_q;
    assign op.index = index_q;
    assign op.tag   = tag_q;
    assign ack      = (state == hold);

endmodule

/* design/result_if.sv */
`timescale 1ns/1ps

interface result_if #(
    parameter int lines   = line_pkg::DEF_LINES,
    parameter int index_w = line_pkg::DEF_INDEX_W
) ();
    import line_pkg::*;

    localparam int tag_w = $clog2(lines);

    logic               valid;
    resp_e              code;
    logic [tag_w-1:0]   tag;
    line_state_e        status;
    logic [index_w-1:0] index;
    // only set by an alloc that evicts a dirty line
    logic               victim_dirty;

    modport source (output valid, output code, output tag, output status,
                    output index, output victim_dirty);
    modport sink (input valid, input code, input tag, input status,
                  input index, input victim_dirty);

endinterface

/* design/op_if.sv */
`timescale 1ns/1ps

interface op_if #(
    parameter int lines   = line_pkg::DEF_LINES,
    parameter int index_w = line_pkg::DEF_INDEX_W
) ();
    import line_pkg::*;

    localparam int tag_w = $clog2(lines);

    logic               valid;
    op_e                op;
    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;

    modport source (output valid, output op, output index, output tag);
    modport sink (input valid, input op, input index, input tag);

endinterface

/* design/line_pkg.sv */
package line_pkg;

    // default table geometry
    localparam int DEF_LINES   = 4;
    localparam int DEF_INDEX_W = 4;

    typedef enum logic [1:0] {
        op_lookup    = 2'd0,
        op_write     = 2'd1,
        op_alloc     = 2'd2,
        op_fill_done = 2'd3
    } op_e;

    typedef enum logic [1:0] {
        st_invalid = 2'd0,
        st_filling = 2'd1,
        st_clean   = 2'd2,
        st_dirty   = 2'd3
    } line_state_e;

    typedef enum logic [1:0] {
        resp_miss = 2'd0,
        resp_hit  = 2'd1,
        resp_done = 2'd2,
        resp_busy = 2'd3
    } resp_e;

endpackage
